/* compile.f */
l15_pkg.sv
l15_fifo.sv
l15_req_path.sv
l15_ret_path.sv
piton_l15_transducer.sv
tb_clkgen.sv
tb_piton_l15_transducer.sv

/* Makefile */
SIM      := verilator
TOP      := tb_piton_l15_transducer
FILELIST := compile.f
FLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := All tests passed!
SRCS     := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_piton_l15_transducer.sv */
`timescale 1ns/1ps

module tb_piton_l15_transducer
  import l15_pkg::*;
;

  localparam int REQ_DEPTH     = 2;
  localparam int RET_DEPTH     = 16;
  localparam int RET_W         = RTNTYPE_WIDTH + 2 + 4 * DWORD_WIDTH + INVAL_ADDR_W + 2
                               + INVAL_WAY_W;
  localparam int CHK_W         = 320;
  localparam int WAIT_TIMEOUT  = 200;
  localparam int DRAIN_TIMEOUT = 500;

  logic clk_i;
  logic rst_n_i;

  logic      icache_req_v_i;
  rqtype_t   icache_req_rqtype_i;
  logic      icache_req_nc_i;
  req_size_t icache_req_size_i;
  paddr_t    icache_req_address_i;
  dword_t    icache_req_data_i;
  rplway_t   icache_req_l1rplway_i;
  amo_op_t   icache_req_amo_op_i;
  logic      icache_req_ready_o;
  logic      dcache_req_v_i;
  rqtype_t   dcache_req_rqtype_i;
  logic      dcache_req_nc_i;
  req_size_t dcache_req_size_i;
  paddr_t    dcache_req_address_i;
  dword_t    dcache_req_data_i;
  rplway_t   dcache_req_l1rplway_i;
  amo_op_t   dcache_req_amo_op_i;
  logic      dcache_req_ready_o;

  logic      transducer_l15_val_o;
  rqtype_t   transducer_l15_rqtype_o;
  logic      transducer_l15_nc_o;
  req_size_t transducer_l15_size_o;
  paddr_t    transducer_l15_address_o;
  dword_t    transducer_l15_data_o;
  rplway_t   transducer_l15_l1rplway_o;
  amo_op_t   transducer_l15_amo_op_o;
  logic      l15_transducer_ack_i;

  logic         l15_transducer_val_i;
  l15_rtntype_e l15_transducer_returntype_i;
  logic         l15_transducer_noncacheable_i;
  logic         l15_transducer_atomic_i;
  dword_t       l15_transducer_data_0_i;
  dword_t       l15_transducer_data_1_i;
  dword_t       l15_transducer_data_2_i;
  dword_t       l15_transducer_data_3_i;
  inval_addr_t  l15_transducer_inval_address_15_4_i;
  logic         l15_transducer_inval_icache_inval_i;
  logic         l15_transducer_inval_dcache_inval_i;
  inval_way_t   l15_transducer_inval_way_i;
  logic         transducer_l15_req_ack_o;

  l15_rtntype_e ret_rtntype_o;
  logic         ret_noncacheable_o;
  logic         ret_atomic_o;
  dword_t       ret_data_0_o;
  dword_t       ret_data_1_o;
  dword_t       ret_data_2_o;
  dword_t       ret_data_3_o;
  inval_addr_t  ret_inval_address_o;
  logic         ret_inval_icache_o;
  logic         ret_inval_dcache_o;
  inval_way_t   ret_inval_way_o;
  logic         icache_ret_v_o;
  logic         dcache_ret_v_o;
  logic         icache_ret_yumi_i;
  logic         dcache_ret_yumi_i;

  // Reference queues advanced at each rising edge
  logic [REQ_WIDTH-1:0] ic_q[$];
  logic [REQ_WIDTH-1:0] dc_q[$];
  logic [RET_W-1:0]     ret_q[$];
  bit                   ret_pending;

  int unsigned ic_pct;
  int unsigned dc_pct;
  int unsigned ack_pct;
  int unsigned rv_pct;
  int unsigned yumi_pct;
  bit          last_ack;
  bit          last_ic_ready;
  bit          last_dc_ready;

  tb_clkgen #(.PERIOD_NS(100)) u_clkgen (.clk_o(clk_i));

  piton_l15_transducer #(
    .REQ_FIFO_DEPTH (REQ_DEPTH),
    .RET_FIFO_DEPTH (RET_DEPTH)
  ) uut (.*);

  task automatic check_value(input string name, input logic [CHK_W-1:0] actual,
                             input logic [CHK_W-1:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED time=%0t signal=%s actual=%0h expected=%0h",
               $time, name, actual, expected);
      $display("Test failures found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Test failures found");
    $fatal(1, "stopping on timeout");
  endtask

  function automatic bit chance(input int unsigned pct);
    return ($urandom % 100) < pct;
  endfunction

  function automatic l15_rtntype_e pick_rtntype(input int unsigned k);
    case (k % 6)
      0:       return e_load_ret;
      1:       return e_ifill_ret;
      2:       return e_evict_req;
      3:       return e_st_ack;
      4:       return e_int_ret;
      default: return e_atomic_ret;
    endcase
  endfunction

  // Loads, stores and atomics never go to the instruction side
  function automatic bit icache_takes(input logic [RTNTYPE_WIDTH-1:0] t);
    return !((t == e_load_ret) || (t == e_st_ack) || (t == e_atomic_ret));
  endfunction

  function automatic bit dcache_takes(input logic [RTNTYPE_WIDTH-1:0] t);
    return t != e_ifill_ret;
  endfunction

  function automatic logic [RTNTYPE_WIDTH-1:0] head_type();
    return ret_q[0][RET_W-1 -: RTNTYPE_WIDTH];
  endfunction

  task automatic set_mix(input int unsigned ic, input int unsigned dc, input int unsigned ack,
                         input int unsigned rv, input int unsigned yumi);
    ic_pct   = ic;
    dc_pct   = dc;
    ack_pct  = ack;
    rv_pct   = rv;
    yumi_pct = yumi;
  endtask

  task automatic drive_inputs();
    icache_req_v_i        = chance(ic_pct);
    icache_req_rqtype_i   = rqtype_t'($urandom);
    icache_req_nc_i       = 1'($urandom);
    icache_req_size_i     = req_size_t'($urandom);
    icache_req_address_i  = paddr_t'({$urandom, $urandom});
    icache_req_data_i     = {$urandom, $urandom};
    icache_req_l1rplway_i = rplway_t'($urandom);
    icache_req_amo_op_i   = amo_op_t'($urandom);
    dcache_req_v_i        = chance(dc_pct);
    dcache_req_rqtype_i   = rqtype_t'($urandom);
    dcache_req_nc_i       = 1'($urandom);
    dcache_req_size_i     = req_size_t'($urandom);
    dcache_req_address_i  = paddr_t'({$urandom, $urandom});
    dcache_req_data_i     = {$urandom, $urandom};
    dcache_req_l1rplway_i = rplway_t'($urandom);
    dcache_req_amo_op_i   = amo_op_t'($urandom);
    l15_transducer_ack_i  = chance(ack_pct);
    // L1.5 keeps a return steady until it is acked
    if (!ret_pending) begin
      l15_transducer_val_i                = chance(rv_pct);
      l15_transducer_returntype_i         = pick_rtntype($urandom);
      l15_transducer_noncacheable_i       = 1'($urandom);
      l15_transducer_atomic_i             = 1'($urandom);
      l15_transducer_data_0_i             = {$urandom, $urandom};
      l15_transducer_data_1_i             = {$urandom, $urandom};
      l15_transducer_data_2_i             = {$urandom, $urandom};
      l15_transducer_data_3_i             = {$urandom, $urandom};
      l15_transducer_inval_address_15_4_i = inval_addr_t'($urandom);
      l15_transducer_inval_icache_inval_i = 1'($urandom);
      l15_transducer_inval_dcache_inval_i = 1'($urandom);
      l15_transducer_inval_way_i          = inval_way_t'($urandom);
    end
    icache_ret_yumi_i = 1'b0;
    dcache_ret_yumi_i = 1'b0;
    if (ret_q.size() > 0) begin
      icache_ret_yumi_i = icache_takes(head_type()) && chance(yumi_pct);
      dcache_ret_yumi_i = dcache_takes(head_type()) && chance(yumi_pct);
    end
  endtask

  task automatic compare_outputs();
    logic [REQ_WIDTH-1:0] exp_req;
    logic [REQ_WIDTH-1:0] got_req;
    logic [RET_W-1:0]     got_ret;
    check_value("icache_req_ready_o", icache_req_ready_o, ic_q.size() < REQ_DEPTH);
    check_value("dcache_req_ready_o", dcache_req_ready_o, dc_q.size() < REQ_DEPTH);
    check_value("transducer_l15_val_o", transducer_l15_val_o,
                (ic_q.size() + dc_q.size()) > 0);
    if ((ic_q.size() + dc_q.size()) > 0) begin
      exp_req = (dc_q.size() > 0) ? dc_q[0] : ic_q[0];
      got_req = {transducer_l15_rqtype_o, transducer_l15_nc_o, transducer_l15_size_o,
                 transducer_l15_address_o, transducer_l15_data_o,
                 transducer_l15_l1rplway_o, transducer_l15_amo_op_o};
      check_value("transducer_l15 request fields", got_req, exp_req);
    end
    check_value("transducer_l15_req_ack_o", transducer_l15_req_ack_o,
                l15_transducer_val_i && (ret_q.size() < RET_DEPTH));
    if (ret_q.size() > 0) begin
      check_value("icache_ret_v_o", icache_ret_v_o, icache_takes(head_type()));
      check_value("dcache_ret_v_o", dcache_ret_v_o, dcache_takes(head_type()));
      got_ret = {ret_rtntype_o, ret_noncacheable_o, ret_atomic_o, ret_data_0_o,
                 ret_data_1_o, ret_data_2_o, ret_data_3_o, ret_inval_address_o,
                 ret_inval_icache_o, ret_inval_dcache_o, ret_inval_way_o};
      check_value("return fields", got_ret, ret_q[0]);
    end else begin
      check_value("icache_ret_v_o", icache_ret_v_o, 1'b0);
      check_value("dcache_ret_v_o", dcache_ret_v_o, 1'b0);
    end
    last_ack      = transducer_l15_req_ack_o;
    last_ic_ready = icache_req_ready_o;
    last_dc_ready = dcache_req_ready_o;
  endtask

  task automatic update_models();
    bit ic_acc;
    bit dc_acc;
    bit r_acc;
    bit r_pop;
    ic_acc = icache_req_v_i && (ic_q.size() < REQ_DEPTH);
    dc_acc = dcache_req_v_i && (dc_q.size() < REQ_DEPTH);
    r_acc  = l15_transducer_val_i && (ret_q.size() < RET_DEPTH);
    r_pop  = (icache_ret_yumi_i || dcache_ret_yumi_i) && (ret_q.size() > 0);
    if (l15_transducer_ack_i && (dc_q.size() > 0)) begin
      void'(dc_q.pop_front());
    end else if (l15_transducer_ack_i && (ic_q.size() > 0)) begin
      void'(ic_q.pop_front());
    end
    if (ic_acc) begin
      ic_q.push_back({icache_req_rqtype_i, icache_req_nc_i, icache_req_size_i,
                      icache_req_address_i, icache_req_data_i, icache_req_l1rplway_i,
                      icache_req_amo_op_i});
    end
    if (dc_acc) begin
      dc_q.push_back({dcache_req_rqtype_i, dcache_req_nc_i, dcache_req_size_i,
                      dcache_req_address_i, dcache_req_data_i, dcache_req_l1rplway_i,
                      dcache_req_amo_op_i});
    end
    if (r_pop) begin
      void'(ret_q.pop_front());
    end
    if (r_acc) begin
      ret_q.push_back({l15_transducer_returntype_i, l15_transducer_noncacheable_i,
                       l15_transducer_atomic_i, l15_transducer_data_0_i,
                       l15_transducer_data_1_i, l15_transducer_data_2_i,
                       l15_transducer_data_3_i, l15_transducer_inval_address_15_4_i,
                       l15_transducer_inval_icache_inval_i,
                       l15_transducer_inval_dcache_inval_i, l15_transducer_inval_way_i});
    end
    ret_pending = l15_transducer_val_i && !r_acc;
  endtask

  // Drive at the falling edge, check mid-cycle, update the reference at the rising edge
  task automatic step_cycle();
    @(negedge clk_i);
    drive_inputs();
    #20;
    compare_outputs();
    @(posedge clk_i);
    update_models();
  endtask

  task automatic run_cycles(input int n);
    repeat (n) begin
      step_cycle();
    end
  endtask

  task automatic drain_all();
    int n;
    n = 0;
    set_mix(0, 0, 100, 0, 100);
    while ((ic_q.size() + dc_q.size() + ret_q.size()) != 0 || ret_pending) begin
      if (n == DRAIN_TIMEOUT) begin
        report_timeout("the request and return queues to drain");
      end
      step_cycle();
      n++;
    end
    step_cycle();
  endtask

  task automatic fill_until_full(input bit dcache_side, output int accepted);
    int n;
    bit ready;
    n        = 0;
    accepted = 0;
    ready    = 1'b1;
    while (ready) begin
      if (n == WAIT_TIMEOUT) begin
        report_timeout(dcache_side ? "dcache_req_ready_o to drop" : "icache_req_ready_o to drop");
      end
      step_cycle();
      n++;
      ready = dcache_side ? last_dc_ready : last_ic_ready;
      if (ready) begin
        accepted++;
      end
    end
  endtask

  initial begin
    int accepted;
    int acks;
    int n;
    void'($urandom(32'hc31166e3));
    rst_n_i = 1'b0;
    ret_pending = 1'b0;
    set_mix(0, 0, 0, 0, 0);
    icache_req_v_i = 1'b0;
    icache_req_rqtype_i = '0;
    icache_req_nc_i = 1'b0;
    icache_req_size_i = '0;
    icache_req_address_i = '0;
    icache_req_data_i = '0;
    icache_req_l1rplway_i = '0;
    icache_req_amo_op_i = '0;
    dcache_req_v_i = 1'b0;
    dcache_req_rqtype_i = '0;
    dcache_req_nc_i = 1'b0;
    dcache_req_size_i = '0;
    dcache_req_address_i = '0;
    dcache_req_data_i = '0;
    dcache_req_l1rplway_i = '0;
    dcache_req_amo_op_i = '0;
    l15_transducer_ack_i = 1'b0;
    l15_transducer_val_i = 1'b0;
    l15_transducer_returntype_i = e_load_ret;
    l15_transducer_noncacheable_i = 1'b0;
    l15_transducer_atomic_i = 1'b0;
    l15_transducer_data_0_i = '0;
    l15_transducer_data_1_i = '0;
    l15_transducer_data_2_i = '0;
    l15_transducer_data_3_i = '0;
    l15_transducer_inval_address_15_4_i = '0;
    l15_transducer_inval_icache_inval_i = 1'b0;
    l15_transducer_inval_dcache_inval_i = 1'b0;
    l15_transducer_inval_way_i = '0;
    icache_ret_yumi_i = 1'b0;
    dcache_ret_yumi_i = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Idle after reset
    run_cycles(2);

    // One channel at a time
    set_mix(60, 0, 70, 0, 0);
    run_cycles(200);
    drain_all();
    set_mix(0, 60, 70, 0, 0);
    run_cycles(200);
    drain_all();

    // Both channels with random ack
    set_mix(50, 50, 50, 0, 0);
    run_cycles(400);
    drain_all();

    // Request back-pressure with icache first
    set_mix(100, 0, 0, 0, 0);
    fill_until_full(1'b0, accepted);
    check_value("icache requests accepted", accepted, REQ_DEPTH);
    set_mix(0, 0, 100, 0, 0);
    step_cycle();
    set_mix(0, 0, 0, 0, 0);
    step_cycle();
    check_value("icache_req_ready_o after pop", last_ic_ready, 1'b1);
    // dcache entries overtake the waiting icache ones
    set_mix(0, 100, 0, 0, 0);
    fill_until_full(1'b1, accepted);
    check_value("dcache requests accepted", accepted, REQ_DEPTH);
    set_mix(0, 0, 100, 0, 0);
    step_cycle();
    set_mix(0, 0, 0, 0, 0);
    step_cycle();
    check_value("dcache_req_ready_o after pop", last_dc_ready, 1'b1);
    drain_all();

    // Random returns of all types
    set_mix(0, 0, 0, 60, 50);
    run_cycles(400);
    drain_all();

    // Return queue fills with no yumi
    set_mix(0, 0, 0, 100, 0);
    acks = 0;
    n = 0;
    last_ack = 1'b1;
    while (last_ack) begin
      if (n == WAIT_TIMEOUT) begin
        report_timeout("transducer_l15_req_ack_o to stay low on a full return queue");
      end
      step_cycle();
      n++;
      if (last_ack) begin
        acks++;
      end
    end
    check_value("returns acked before full", acks, RET_DEPTH);
    run_cycles(3);
    set_mix(0, 0, 0, 100, 100);
    step_cycle();
    set_mix(0, 0, 0, 100, 0);
    step_cycle();
    check_value("transducer_l15_req_ack_o after yumi", last_ack, 1'b1);
    drain_all();

    $display("All tests passed!");
    $finish;
  end

endmodule

/* tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

endmodule

/* piton_l15_transducer.sv */
`timescale 1ns/1ps

module piton_l15_transducer
  import l15_pkg::*;
#(
  parameter int REQ_FIFO_DEPTH = 2,
  parameter int RET_FIFO_DEPTH = 16
) (
  input  logic         clk_i,
  input  logic         rst_n_i,

  // Instruction cache requests
  input  logic         icache_req_v_i,
  input  rqtype_t      icache_req_rqtype_i,
  input  logic         icache_req_nc_i,
  input  req_size_t    icache_req_size_i,
  input  paddr_t       icache_req_address_i,
  input  dword_t       icache_req_data_i,
  input  rplway_t      icache_req_l1rplway_i,
  input  amo_op_t      icache_req_amo_op_i,
  output logic         icache_req_ready_o,

  // Data cache requests
  input  logic         dcache_req_v_i,
  input  rqtype_t      dcache_req_rqtype_i,
  input  logic         dcache_req_nc_i,
  input  req_size_t    dcache_req_size_i,
  input  paddr_t       dcache_req_address_i,
  input  dword_t       dcache_req_data_i,
  input  rplway_t      dcache_req_l1rplway_i,
  input  amo_op_t      dcache_req_amo_op_i,
  output logic         dcache_req_ready_o,

  output logic         transducer_l15_val_o,
  output rqtype_t      transducer_l15_rqtype_o,
  output logic         transducer_l15_nc_o,
  output req_size_t    transducer_l15_size_o,
  output paddr_t       transducer_l15_address_o,
  output dword_t       transducer_l15_data_o,
  output rplway_t      transducer_l15_l1rplway_o,
  output amo_op_t      transducer_l15_amo_op_o,
  input  logic         l15_transducer_ack_i,

  input  logic         l15_transducer_val_i,
  input  l15_rtntype_e l15_transducer_returntype_i,
  input  logic         l15_transducer_noncacheable_i,
  input  logic         l15_transducer_atomic_i,
  input  dword_t       l15_transducer_data_0_i,
  input  dword_t       l15_transducer_data_1_i,
  input  dword_t       l15_transducer_data_2_i,
  input  dword_t       l15_transducer_data_3_i,
  input  inval_addr_t  l15_transducer_inval_address_15_4_i,
  input  logic         l15_transducer_inval_icache_inval_i,
  input  logic         l15_transducer_inval_dcache_inval_i,
  input  inval_way_t   l15_transducer_inval_way_i,
  output logic         transducer_l15_req_ack_o,

  // Shared return fields for both engines
  output l15_rtntype_e ret_rtntype_o,
  output logic         ret_noncacheable_o,
  output logic         ret_atomic_o,
  output dword_t       ret_data_0_o,
  output dword_t       ret_data_1_o,
  output dword_t       ret_data_2_o,
  output dword_t       ret_data_3_o,
  output inval_addr_t  ret_inval_address_o,
  output logic         ret_inval_icache_o,
  output logic         ret_inval_dcache_o,
  output inval_way_t   ret_inval_way_o,
  output logic         icache_ret_v_o,
  output logic         dcache_ret_v_o,
  input  logic         icache_ret_yumi_i,
  input  logic         dcache_ret_yumi_i
);

  l15_req_path #(
    .REQ_FIFO_DEPTH (REQ_FIFO_DEPTH)
  ) u_req_path (
    .clk_i                     (clk_i),
    .rst_n_i                   (rst_n_i),
    .icache_req_v_i            (icache_req_v_i),
    .icache_req_rqtype_i       (icache_req_rqtype_i),
    .icache_req_nc_i           (icache_req_nc_i),
    .icache_req_size_i         (icache_req_size_i),
    .icache_req_address_i      (icache_req_address_i),
    .icache_req_data_i         (icache_req_data_i),
    .icache_req_l1rplway_i     (icache_req_l1rplway_i),
    .icache_req_amo_op_i       (icache_req_amo_op_i),
    .icache_req_ready_o        (icache_req_ready_o),
    .dcache_req_v_i            (dcache_req_v_i),
    .dcache_req_rqtype_i       (dcache_req_rqtype_i),
    .dcache_req_nc_i           (dcache_req_nc_i),
    .dcache_req_size_i         (dcache_req_size_i),
    .dcache_req_address_i      (dcache_req_address_i),
    .dcache_req_data_i         (dcache_req_data_i),
    .dcache_req_l1rplway_i     (dcache_req_l1rplway_i),
    .dcache_req_amo_op_i       (dcache_req_amo_op_i),
    .dcache_req_ready_o        (dcache_req_ready_o),
    .transducer_l15_val_o      (transducer_l15_val_o),
    .transducer_l15_rqtype_o   (transducer_l15_rqtype_o),
    .transducer_l15_nc_o       (transducer_l15_nc_o),
    .transducer_l15_size_o     (transducer_l15_size_o),
    .transducer_l15_address_o  (transducer_l15_address_o),
    .transducer_l15_data_o     (transducer_l15_data_o),
    .transducer_l15_l1rplway_o (transducer_l15_l1rplway_o),
    .transducer_l15_amo_op_o   (transducer_l15_amo_op_o),
    .l15_transducer_ack_i      (l15_transducer_ack_i)
  );

  l15_ret_path #(
    .RET_FIFO_DEPTH (RET_FIFO_DEPTH)
  ) u_ret_path (
    .clk_i                               (clk_i),
    .rst_n_i                             (rst_n_i),
    .l15_transducer_val_i                (l15_transducer_val_i),
    .l15_transducer_returntype_i         (l15_transducer_returntype_i),
    .l15_transducer_noncacheable_i       (l15_transducer_noncacheable_i),
    .l15_transducer_atomic_i             (l15_transducer_atomic_i),
    .l15_transducer_data_0_i             (l15_transducer_data_0_i),
    .l15_transducer_data_1_i             (l15_transducer_data_1_i),
    .l15_transducer_data_2_i             (l15_transducer_data_2_i),
    .l15_transducer_data_3_i             (l15_transducer_data_3_i),
    .l15_transducer_inval_address_15_4_i (l15_transducer_inval_address_15_4_i),
    .l15_transducer_inval_icache_inval_i (l15_transducer_inval_icache_inval_i),
    .l15_transducer_inval_dcache_inval_i (l15_transducer_inval_dcache_inval_i),
    .l15_transducer_inval_way_i          (l15_transducer_inval_way_i),
    .transducer_l15_req_ack_o            (transducer_l15_req_ack_o),
    .ret_rtntype_o                       (ret_rtntype_o),
    .ret_noncacheable_o                  (ret_noncacheable_o),
    .ret_atomic_o                        (ret_atomic_o),
    .ret_data_0_o                        (ret_data_0_o),
    .ret_data_1_o                        (ret_data_1_o),
    .ret_data_2_o                        (ret_data_2_o),
    .ret_data_3_o                        (ret_data_3_o),
    .ret_inval_address_o                 (ret_inval_address_o),
    .ret_inval_icache_o                  (ret_inval_icache_o),
    .ret_inval_dcache_o                  (ret_inval_dcache_o),
    .ret_inval_way_o                     (ret_inval_way_o),
    .icache_ret_v_o                      (icache_ret_v_o),
    .dcache_ret_v_o                      (dcache_ret_v_o),
    .icache_ret_yumi_i                   (icache_ret_yumi_i),
    .dcache_ret_yumi_i                   (dcache_ret_yumi_i)
  );

endmodule

/* l15_ret_path.sv */
`timescale 1ns/1ps

module l15_ret_path
  import l15_pkg::*;
#(
  parameter int RET_FIFO_DEPTH = 16
) (
  input  logic         clk_i,
  input  logic         rst_n_i,

  input  logic         l15_transducer_val_i,
  input  l15_rtntype_e l15_transducer_returntype_i,
  input  logic         l15_transducer_noncacheable_i,
  input  logic         l15_transducer_atomic_i,
  input  dword_t       l15_transducer_data_0_i,
  input  dword_t       l15_transducer_data_1_i,
  input  dword_t       l15_transducer_data_2_i,
  input  dword_t       l15_transducer_data_3_i,
  input  inval_addr_t  l15_transducer_inval_address_15_4_i,
  input  logic         l15_transducer_inval_icache_inval_i,
  input  logic         l15_transducer_inval_dcache_inval_i,
  input  inval_way_t   l15_transducer_inval_way_i,
  output logic         transducer_l15_req_ack_o,

  output l15_rtntype_e ret_rtntype_o,
  output logic         ret_noncacheable_o,
  output logic         ret_atomic_o,
  output dword_t       ret_data_0_o,
  output dword_t       ret_data_1_o,
  output dword_t       ret_data_2_o,
  output dword_t       ret_data_3_o,
  output inval_addr_t  ret_inval_address_o,
  output logic         ret_inval_icache_o,
  output logic         ret_inval_dcache_o,
  output inval_way_t   ret_inval_way_o,
  output logic         icache_ret_v_o,
  output logic         dcache_ret_v_o,
  input  logic         icache_ret_yumi_i,
  input  logic         dcache_ret_yumi_i
);

  localparam int RET_WIDTH = RTNTYPE_WIDTH + 2 + 4 * DWORD_WIDTH
                           + INVAL_ADDR_W + 2 + INVAL_WAY_W;

  logic [RET_WIDTH-1:0]     ret_pkt;
  logic [RET_WIDTH-1:0]     head;
  logic [RTNTYPE_WIDTH-1:0] head_rtntype;
  logic                     head_v;
  logic                     fifo_ready;

  assign ret_pkt = {l15_transducer_returntype_i, l15_transducer_noncacheable_i,
                    l15_transducer_atomic_i, l15_transducer_data_0_i,
                    l15_transducer_data_1_i, l15_transducer_data_2_i,
                    l15_transducer_data_3_i, l15_transducer_inval_address_15_4_i,
                    l15_transducer_inval_icache_inval_i,
                    l15_transducer_inval_dcache_inval_i, l15_transducer_inval_way_i};

  // Ack only when there is room, held val retries otherwise
  assign transducer_l15_req_ack_o = l15_transducer_val_i & fifo_ready;

  l15_fifo #(
    .WIDTH (RET_WIDTH),
    .DEPTH (RET_FIFO_DEPTH)
  ) u_ret_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (ret_pkt),
    .v_i     (l15_transducer_val_i),
    .ready_o (fifo_ready),
    .data_o  (head),
    .v_o     (head_v),
    .yumi_i  (icache_ret_yumi_i | dcache_ret_yumi_i)
  );

  assign {head_rtntype, ret_noncacheable_o, ret_atomic_o, ret_data_0_o, ret_data_1_o,
          ret_data_2_o, ret_data_3_o, ret_inval_address_o, ret_inval_icache_o,
          ret_inval_dcache_o, ret_inval_way_o} = head;

  assign ret_rtntype_o = l15_rtntype_e'(head_rtntype);

  // Steering by type; invalidations and the rest go to both
  assign icache_ret_v_o = head_v & ~((ret_rtntype_o == e_load_ret)
                                   | (ret_rtntype_o == e_st_ack)
                                   | (ret_rtntype_o == e_atomic_ret));
  assign dcache_ret_v_o = head_v & (ret_rtntype_o != e_ifill_ret);

endmodule

/* l15_req_path.sv */
`timescale 1ns/1ps

module l15_req_path
  import l15_pkg::*;
#(
  parameter int REQ_FIFO_DEPTH = 2
) (
  input  logic      clk_i,
  input  logic      rst_n_i,

  input  logic      icache_req_v_i,
  input  rqtype_t   icache_req_rqtype_i,
  input  logic      icache_req_nc_i,
  input  req_size_t icache_req_size_i,
  input  paddr_t    icache_req_address_i,
  input  dword_t    icache_req_data_i,
  input  rplway_t   icache_req_l1rplway_i,
  input  amo_op_t   icache_req_amo_op_i,
  output logic      icache_req_ready_o,

  input  logic      dcache_req_v_i,
  input  rqtype_t   dcache_req_rqtype_i,
  input  logic      dcache_req_nc_i,
  input  req_size_t dcache_req_size_i,
  input  paddr_t    dcache_req_address_i,
  input  dword_t    dcache_req_data_i,
  input  rplway_t   dcache_req_l1rplway_i,
  input  amo_op_t   dcache_req_amo_op_i,
  output logic      dcache_req_ready_o,

  output logic      transducer_l15_val_o,
  output rqtype_t   transducer_l15_rqtype_o,
  output logic      transducer_l15_nc_o,
  output req_size_t transducer_l15_size_o,
  output paddr_t    transducer_l15_address_o,
  output dword_t    transducer_l15_data_o,
  output rplway_t   transducer_l15_l1rplway_o,
  output amo_op_t   transducer_l15_amo_op_o,
  input  logic      l15_transducer_ack_i
);

  logic [REQ_WIDTH-1:0] icache_pkt;
  logic [REQ_WIDTH-1:0] dcache_pkt;
  logic [REQ_WIDTH-1:0] icache_head;
  logic [REQ_WIDTH-1:0] dcache_head;
  logic [REQ_WIDTH-1:0] sel_head;
  logic                 icache_head_v;
  logic                 dcache_head_v;
  logic                 icache_grant;
  logic                 dcache_grant;

  assign icache_pkt = {icache_req_rqtype_i, icache_req_nc_i, icache_req_size_i,
                       icache_req_address_i, icache_req_data_i, icache_req_l1rplway_i,
                       icache_req_amo_op_i};

  assign dcache_pkt = {dcache_req_rqtype_i, dcache_req_nc_i, dcache_req_size_i,
                       dcache_req_address_i, dcache_req_data_i, dcache_req_l1rplway_i,
                       dcache_req_amo_op_i};

  l15_fifo #(
    .WIDTH (REQ_WIDTH),
    .DEPTH (REQ_FIFO_DEPTH)
  ) u_icache_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (icache_pkt),
    .v_i     (icache_req_v_i),
    .ready_o (icache_req_ready_o),
    .data_o  (icache_head),
    .v_o     (icache_head_v),
    .yumi_i  (icache_grant & l15_transducer_ack_i)
  );

  l15_fifo #(
    .WIDTH (REQ_WIDTH),
    .DEPTH (REQ_FIFO_DEPTH)
  ) u_dcache_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (dcache_pkt),
    .v_i     (dcache_req_v_i),
    .ready_o (dcache_req_ready_o),
    .data_o  (dcache_head),
    .v_o     (dcache_head_v),
    .yumi_i  (dcache_grant & l15_transducer_ack_i)
  );

  // Fixed priority, data cache first
  assign dcache_grant = dcache_head_v;
  assign icache_grant = icache_head_v & ~dcache_head_v;

  assign sel_head             = dcache_grant ? dcache_head : icache_head;
  assign transducer_l15_val_o = dcache_grant | icache_grant;

  assign {transducer_l15_rqtype_o, transducer_l15_nc_o, transducer_l15_size_o,
          transducer_l15_address_o, transducer_l15_data_o, transducer_l15_l1rplway_o,
          transducer_l15_amo_op_o} = sel_head;

endmodule

/* l15_fifo.sv */
`timescale 1ns/1ps

module l15_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             v_i,
  output logic             ready_o,
  output logic [WIDTH-1:0] data_o,
  output logic             v_o,
  input  logic             yumi_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             wr_en;
  logic             rd_en;

  // Wrap at DEPTH, so any depth works
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign ready_o = (count_q != CNT_W'(DEPTH));
  assign v_o     = (count_q != '0);
  assign wr_en   = v_i & ready_o;
  assign rd_en   = yumi_i & v_o;

  // Head straight from storage
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (rd_en) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* l15_pkg.sv */
package l15_pkg;

  // Widths on the L1.5 interface
  localparam int PADDR_WIDTH = 40;
  localparam int DWORD_WIDTH = 64;

  localparam int RQTYPE_WIDTH   = 5;
  localparam int SIZE_WIDTH     = 3;
  localparam int RPLWAY_WIDTH   = 2;
  localparam int AMO_OP_WIDTH   = 4;
  localparam int INVAL_ADDR_W   = 12;
  localparam int INVAL_WAY_W    = 2;
  localparam int RTNTYPE_WIDTH  = 4;

  typedef logic [PADDR_WIDTH-1:0]  paddr_t;
  typedef logic [DWORD_WIDTH-1:0]  dword_t;
  typedef logic [RQTYPE_WIDTH-1:0] rqtype_t;
  typedef logic [SIZE_WIDTH-1:0]   req_size_t;
  typedef logic [RPLWAY_WIDTH-1:0] rplway_t;
  typedef logic [AMO_OP_WIDTH-1:0] amo_op_t;
  typedef logic [INVAL_ADDR_W-1:0] inval_addr_t;
  typedef logic [INVAL_WAY_W-1:0]  inval_way_t;

  // Packed request: rqtype, nc, size, address, data, l1rplway, amo_op
  localparam int REQ_WIDTH = RQTYPE_WIDTH
                           + 1
                           + SIZE_WIDTH
                           + PADDR_WIDTH
                           + DWORD_WIDTH
                           + RPLWAY_WIDTH
                           + AMO_OP_WIDTH;

  // Return types seen from the L1.5
  typedef enum logic [RTNTYPE_WIDTH-1:0] {
    e_load_ret   = 4'd0,
    e_ifill_ret  = 4'd1,
    e_evict_req  = 4'd3,
    e_st_ack     = 4'd4,
    e_int_ret    = 4'd7,
    e_atomic_ret = 4'd8
  } l15_rtntype_e;

endpackage
